//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = wb_xbar_tb
FLIST    = flist.f
BUILD    = obj_dir
LOG      = sim.log
RUNARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "TESTS FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

//--- flist.f
hw/wb_xbar_pkg.sv
hw/wb_rr_arbiter.sv
hw/wb_master_port.sv
hw/wb_slave_port.sv
hw/wb_decode_err_target.sv
hw/wb_xbar_3x3.sv
verif/wb_xbar_assert.sv
verif/wb_xbar_tb.sv

//--- hw/wb_decode_err_target.sv
`timescale 1ns/1ps

module wb_decode_err_target (
	input logic clk,
	input logic rstn,
	// Request routed here for unmapped addresses
	input wb_xbar_pkg::wb_req_t req_i,
	output wb_xbar_pkg::wb_rsp_t rsp_o
);

	// Error pulse
	logic err_q;

	// One err per strobe, a cycle late
	// No second pulse while the first is still out
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_i.cyc && req_i.stb && !err_q;
		end
	end

	// Never acks and returns no data
	always_comb begin
		rsp_o = '0;
		rsp_o.err = err_q;
	end

endmodule

//--- hw/wb_master_port.sv
`timescale 1ns/1ps

module wb_master_port #(
	parameter wb_xbar_pkg::master_id_t MASTER_ID = '0,
	parameter wb_xbar_pkg::addr_window_t [wb_xbar_pkg::N_SLAVES-1:0] SLAVE_WINDOWS = '0
) (
	input logic clk,
	input logic rstn,
	// Request from the external master
	input wb_xbar_pkg::wb_req_t req_i,
	// Registered target selection toward all slave ports
	output wb_xbar_pkg::target_id_t sel_o,
	output logic sel_vld_o,
	// Grant state of every target
	input logic [wb_xbar_pkg::N_TARGETS-1:0] gnt_vld_i,
	input wb_xbar_pkg::master_id_t [wb_xbar_pkg::N_TARGETS-1:0] gnt_id_i,
	// Responses of every target
	input wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_TARGETS-1:0] slv_rsp_i,
	// Response back to the external master
	output wb_xbar_pkg::wb_rsp_t rsp_o
);

	// Tracker state, high while a cycle is in flight
	logic busy_q;
	wb_xbar_pkg::target_id_t sel_q;
	// Combinational decode of the current address
	wb_xbar_pkg::target_id_t dec_tgt;
	// Selected target is granted to this master
	logic own_gnt;
	// Cycle is finished this clock
	logic done;

	// Address decode
	// Windows are checked in order, the lowest matching index wins
	always_comb begin
		dec_tgt = wb_xbar_pkg::TGT_DECERR;
		for (int i = wb_xbar_pkg::N_SLAVES - 1; i >= 0; i--) begin
			if (req_i.adr >= SLAVE_WINDOWS[i].base && req_i.adr <= SLAVE_WINDOWS[i].limit) begin
				dec_tgt = wb_xbar_pkg::target_id_t'(i);
			end
		end
	end

	// Return path only opens while the target's grant points at us
	assign own_gnt = busy_q && gnt_vld_i[sel_q] && (gnt_id_i[sel_q] == MASTER_ID);

	always_comb begin
		rsp_o = '0;
		if (own_gnt) begin
			rsp_o = slv_rsp_i[sel_q];
		end
	end

	// Response ends the cycle, so does a master giving up cyc
	assign done = rsp_o.ack || rsp_o.err || !req_i.cyc;

	// Two-state cycle tracker
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			sel_q <= wb_xbar_pkg::TGT_DECERR;
		end else begin
			if (!busy_q) begin
				// New cycle, latch the decoded target
				if (req_i.cyc && req_i.stb) begin
					busy_q <= 1'b1;
					sel_q <= dec_tgt;
				end
			end else begin
				// Hold the selection until the response is seen
				if (done) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	assign sel_o = sel_q;
	assign sel_vld_o = busy_q;

endmodule

//--- hw/wb_rr_arbiter.sv
`timescale 1ns/1ps

module wb_rr_arbiter #(
	parameter int N_REQ = 3
) (
	input logic clk,
	input logic rstn,
	// One request bit per master
	input logic [N_REQ-1:0] req_i,
	output logic gnt_vld_o,
	output wb_xbar_pkg::master_id_t gnt_id_o
);

	// Current grant
	logic gnt_vld_q;
	wb_xbar_pkg::master_id_t gnt_id_q;
	// Last granted master, the round-robin pointer
	wb_xbar_pkg::master_id_t last_q;
	// Next candidate
	logic pick_vld;
	wb_xbar_pkg::master_id_t pick_id;

	// Round-robin pick
	always_comb begin
		pick_vld = 1'b0;
		pick_id = '0;
		// Fallback is the lowest requester overall
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				pick_vld = 1'b1;
				pick_id = wb_xbar_pkg::master_id_t'(i);
			end
		end
		// Lowest requester above the last grant takes precedence
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i] && (i > int'(last_q))) begin
				pick_id = wb_xbar_pkg::master_id_t'(i);
			end
		end
	end

	// Grant holder
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_vld_q <= 1'b0;
			gnt_id_q <= '0;
			// Pointer at the top so master 0 wins first
			last_q <= wb_xbar_pkg::master_id_t'(N_REQ - 1);
		end else begin
			if (!gnt_vld_q) begin
				if (pick_vld) begin
					gnt_vld_q <= 1'b1;
					gnt_id_q <= pick_id;
					last_q <= pick_id;
				end
			end else begin
				// Release one cycle after the owner drops its request
				if (!req_i[gnt_id_q]) begin
					gnt_vld_q <= 1'b0;
				end
			end
		end
	end

	assign gnt_vld_o = gnt_vld_q;
	assign gnt_id_o = gnt_id_q;

endmodule

//--- hw/wb_slave_port.sv
`timescale 1ns/1ps

module wb_slave_port #(
	parameter wb_xbar_pkg::target_id_t TARGET_ID = '0
) (
	input logic clk,
	input logic rstn,
	// Selections of all masters
	input wb_xbar_pkg::target_id_t [wb_xbar_pkg::N_MASTERS-1:0] sel_i,
	input logic [wb_xbar_pkg::N_MASTERS-1:0] sel_vld_i,
	// Raw requests of all masters
	input wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_MASTERS-1:0] m_req_i,
	// Request toward this target
	output wb_xbar_pkg::wb_req_t s_req_o,
	// Grant back to the master ports
	output logic gnt_vld_o,
	output wb_xbar_pkg::master_id_t gnt_id_o
);

	// Masters currently selecting this target
	logic [wb_xbar_pkg::N_MASTERS-1:0] req_vec;

	always_comb begin
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			req_vec[m] = sel_vld_i[m] && (sel_i[m] == TARGET_ID);
		end
	end

	wb_rr_arbiter #(
		.N_REQ(wb_xbar_pkg::N_MASTERS)
	) arb_inst (
		.clk(clk),
		.rstn(rstn),
		.req_i(req_vec),
		.gnt_vld_o(gnt_vld_o),
		.gnt_id_o(gnt_id_o)
	);

	// Request mux
	// Idle bus is all zero
	always_comb begin
		s_req_o = '0;
		if (gnt_vld_o) begin
			s_req_o = m_req_i[gnt_id_o];
			// Strobe only while the owner still selects us
			// Stops the grant release cycle from leaking a new cycle
			s_req_o.cyc = m_req_i[gnt_id_o].cyc && req_vec[gnt_id_o];
			s_req_o.stb = m_req_i[gnt_id_o].stb && req_vec[gnt_id_o];
		end
	end

endmodule

//--- hw/wb_xbar_3x3.sv
`timescale 1ns/1ps

module wb_xbar_3x3 #(
	// Default map: three 4 KB windows
	parameter wb_xbar_pkg::addr_window_t [wb_xbar_pkg::N_SLAVES-1:0] SLAVE_WINDOWS = '{
		0: '{base: 32'h0000_1000, limit: 32'h0000_1fff},
		1: '{base: 32'h0000_2000, limit: 32'h0000_2fff},
		2: '{base: 32'h0000_3000, limit: 32'h0000_3fff}
	}
) (
	input logic clk,
	input logic rstn,
	// Master side
	input wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_MASTERS-1:0] m_req_i,
	output wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_MASTERS-1:0] m_rsp_o,
	// Slave side
	output wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_SLAVES-1:0] s_req_o,
	input wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_SLAVES-1:0] s_rsp_i
);

	// Selections from the master ports
	wb_xbar_pkg::target_id_t [wb_xbar_pkg::N_MASTERS-1:0] sel;
	logic [wb_xbar_pkg::N_MASTERS-1:0] sel_vld;
	// Grants from the slave ports
	logic [wb_xbar_pkg::N_TARGETS-1:0] gnt_vld;
	wb_xbar_pkg::master_id_t [wb_xbar_pkg::N_TARGETS-1:0] gnt_id;
	// Per-target request and response, index 3 is the error target
	wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_TARGETS-1:0] tgt_req;
	wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_TARGETS-1:0] tgt_rsp;
	wb_xbar_pkg::wb_rsp_t err_rsp;

	// Real slaves take the low targets
	assign s_req_o = tgt_req[wb_xbar_pkg::N_SLAVES-1:0];
	assign tgt_rsp = {err_rsp, s_rsp_i};

	// Master ports
	for (genvar m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin : g_mport
		wb_master_port #(
			.MASTER_ID(wb_xbar_pkg::master_id_t'(m)),
			.SLAVE_WINDOWS(SLAVE_WINDOWS)
		) mport_inst (
			.clk(clk),
			.rstn(rstn),
			.req_i(m_req_i[m]),
			.sel_o(sel[m]),
			.sel_vld_o(sel_vld[m]),
			.gnt_vld_i(gnt_vld),
			.gnt_id_i(gnt_id),
			.slv_rsp_i(tgt_rsp),
			.rsp_o(m_rsp_o[m])
		);
	end

	// Slave ports, one per target including the error target
	for (genvar t = 0; t < wb_xbar_pkg::N_TARGETS; t++) begin : g_sport
		wb_slave_port #(
			.TARGET_ID(wb_xbar_pkg::target_id_t'(t))
		) sport_inst (
			.clk(clk),
			.rstn(rstn),
			.sel_i(sel),
			.sel_vld_i(sel_vld),
			.m_req_i(m_req_i),
			.s_req_o(tgt_req[t]),
			.gnt_vld_o(gnt_vld[t]),
			.gnt_id_o(gnt_id[t])
		);
	end

	// Catches every unmapped address
	wb_decode_err_target decerr_inst (
		.clk(clk),
		.rstn(rstn),
		.req_i(tgt_req[wb_xbar_pkg::TGT_DECERR]),
		.rsp_o(err_rsp)
	);

endmodule

//--- hw/wb_xbar_pkg.sv
package wb_xbar_pkg;

	// Bus widths
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W = WB_DATA_W / 8;

	// Crossbar shape
	localparam int N_MASTERS = 3;
	localparam int N_SLAVES = 3;
	// Real slaves plus the internal decode-error target
	localparam int N_TARGETS = N_SLAVES + 1;

	// Index of a routing target
	// 0 to 2 are the real slaves, 3 is the decode-error target
	typedef logic [1:0] target_id_t;

	// Index of a master
	typedef logic [1:0] master_id_t;

	// Unmapped addresses land here
	localparam target_id_t TGT_DECERR = target_id_t'(3);

	// Master-to-slave bundle
	typedef struct packed {
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat_w;
		logic [WB_SEL_W-1:0] sel;
		logic we;
		logic cyc;
		logic stb;
		// Cycle type and burst type, carried through as is
		logic [2:0] cti;
		logic [1:0] bte;
	} wb_req_t;

	// Slave-to-master bundle
	typedef struct packed {
		logic [WB_DATA_W-1:0] dat_r;
		logic ack;
		logic err;
	} wb_rsp_t;

	// Address window of one slave
	// Base and limit are both inclusive
	typedef struct packed {
		logic [WB_ADDR_W-1:0] base;
		logic [WB_ADDR_W-1:0] limit;
	} addr_window_t;

endpackage

//--- verif/wb_xbar_assert.sv
`timescale 1ns/1ps

module wb_xbar_assert (
	input logic clk,
	input logic rstn,
	input wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_MASTERS-1:0] m_req_i,
	input wb_xbar_pkg::wb_rsp_t [wb_xbar_pkg::N_MASTERS-1:0] m_rsp_i,
	input wb_xbar_pkg::wb_req_t [wb_xbar_pkg::N_TARGETS-1:0] tgt_req_i,
	input logic [wb_xbar_pkg::N_TARGETS-1:0] gnt_vld_i,
	input wb_xbar_pkg::master_id_t [wb_xbar_pkg::N_TARGETS-1:0] gnt_id_i
);

	// Number of failed assertions so far
	int fail_cnt = 0;
	// Targets strobed on behalf of each master
	logic [wb_xbar_pkg::N_MASTERS-1:0][wb_xbar_pkg::N_TARGETS-1:0] stb_map;
	logic any_stb;
	logic any_ack;
	logic any_mstb;
	// Some master has strobed since reset
	logic seen_q;

	always_comb begin
		stb_map = '0;
		any_stb = 1'b0;
		any_ack = 1'b0;
		any_mstb = 1'b0;
		for (int t = 0; t < wb_xbar_pkg::N_TARGETS; t++) begin
			if (tgt_req_i[t].stb) any_stb = 1'b1;
			for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
				if (tgt_req_i[t].stb && gnt_vld_i[t] &&
						gnt_id_i[t] == wb_xbar_pkg::master_id_t'(m)) begin
					stb_map[m][t] = 1'b1;
				end
			end
		end
		for (int m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin
			if (m_rsp_i[m].ack) any_ack = 1'b1;
			if (m_req_i[m].cyc && m_req_i[m].stb) any_mstb = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			seen_q <= 1'b0;
		end else if (any_mstb) begin
			seen_q <= 1'b1;
		end
	end

	for (genvar m = 0; m < wb_xbar_pkg::N_MASTERS; m++) begin : g_master
		// One target at a time per master
		a_one_target: assert property (@(posedge clk) disable iff (!rstn) $onehot0(stb_map[m]))
			else begin
				$error("Master %0d strobes more than one target", m);
				fail_cnt++;
			end
		a_ack_err: assert property (@(posedge clk) disable iff (!rstn)
				!(m_rsp_i[m].ack && m_rsp_i[m].err))
			else begin
				$error("Master %0d sees ack and err together", m);
				fail_cnt++;
			end
	end

	// Nothing moves before the first master strobe
	a_quiet: assert property (@(posedge clk) disable iff (!rstn)
			!seen_q |-> (!any_stb && !any_ack))
		else begin
			$error("Strobe or ack before any master strobed");
			fail_cnt++;
		end

endmodule

bind wb_xbar_3x3 wb_xbar_assert assert_inst (
	.clk(clk),
	.rstn(rstn),
	.m_req_i(m_req_i),
	.m_rsp_i(m_rsp_o),
	.tgt_req_i(tgt_req),
	.gnt_vld_i(gnt_vld),
	.gnt_id_i(gnt_id)
);

//--- verif/wb_xbar_tb.sv
`timescale 1ns/1ps

module wb_xbar_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 16;
	localparam int N_FAIR = 6;
	localparam int N_RAND = 300;
	// Directed, decode error, fairness and random transactions
	localparam int N_TXN = 18 + 3 + 3 * N_FAIR + N_RAND;
	localparam int CYC_PER_TXN = 40;
	localparam logic [31:0] UNMAPPED_BASE = 32'h0001_0000;

	// Three 4 KB windows
	localparam wb_xbar_pkg::addr_window_t [2:0] WINDOWS = '{
		0: '{base: 32'h0000_1000, limit: 32'h0000_1fff},
		1: '{base: 32'h0000_2000, limit: 32'h0000_2fff},
		2: '{base: 32'h0000_3000, limit: 32'h0000_3fff}
	};

	logic clk;
	logic rstn;
	wb_xbar_pkg::wb_req_t [2:0] m_req;
	wb_xbar_pkg::wb_rsp_t [2:0] m_rsp;
	wb_xbar_pkg::wb_req_t [2:0] s_req;
	wb_xbar_pkg::wb_rsp_t [2:0] s_rsp;

	// Slave memories and the reference model beside them
	logic [31:0] slv_mem [3][256];
	logic [31:0] ref_mem [3][256];
	// Slave model state
	logic [2:0] slv_pending;
	int slv_wait [3];
	int slv_stb_cnt [3];
	wb_xbar_pkg::wb_req_t slv_last [3];
	// Cycle and burst type last driven by each master
	logic [2:0] drv_cti [3];
	logic [1:0] drv_bte [3];
	// Master order seen at slave 1 in the fairness test
	logic fair_on;
	int fair_order [$];

	int n_checks;
	int n_errors;
	int err_mark;
	int assert_fails;
	int stb_before;
	int last;
	int exp_m;
	int left [3];
	logic [31:0] wdat;
	logic [3:0] wsel;
	int word;

	wb_xbar_3x3 #(
		.SLAVE_WINDOWS(WINDOWS)
	) wb_xbar_3x3_inst (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.s_req_o(s_req),
		.s_rsp_i(s_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog sized from the transaction count
	initial begin
		#(N_TXN * CYC_PER_TXN * CLK_PERIOD);
		$display("Timeout: transactions did not finish within %0d cycles",
			N_TXN * CYC_PER_TXN);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) res[8*b +: 8] = dat[8*b +: 8];
		end
		return res;
	endfunction

	// Fill pattern that depends on every index bit
	function automatic logic [31:0] init_word(input int s, input int i);
		return 32'h5a00_0000 ^ (32'(s) << 28) ^ (32'(i) * 32'h0001_0203);
	endfunction

	// Next grant scans upward from the last grant and wraps
	function automatic int rr_next(input int prev, input logic [2:0] pend);
		int cand;
		for (int k = 1; k <= 3; k++) begin
			cand = (prev + k) % 3;
			if (pend[cand]) return cand;
		end
		return -1;
	endfunction

	// Slave models sample at the edge and answer 1 ns later
	always @(posedge clk) begin : slave_model
		wb_xbar_pkg::wb_rsp_t nxt [3];
		logic [7:0] idx;
		for (int s = 0; s < 3; s++) begin
			nxt[s] = '0;
			idx = s_req[s].adr[9:2];
			if (!rstn) begin
				slv_pending[s] = 1'b0;
			end else if (!s_rsp[s].ack && s_req[s].cyc && s_req[s].stb) begin
				// First sight of a new cycle
				if (!slv_pending[s]) begin
					slv_pending[s] = 1'b1;
					slv_wait[s] = $urandom_range(3, 0);
					slv_stb_cnt[s]++;
					if (fair_on && s == 1) fair_order.push_back(int'(s_req[s].adr[3:2]));
				end
				if (slv_wait[s] == 0) begin
					slv_pending[s] = 1'b0;
					slv_last[s] = s_req[s];
					nxt[s].ack = 1'b1;
					if (s_req[s].we) begin
						slv_mem[s][idx] = merge_bytes(slv_mem[s][idx], s_req[s].dat_w,
							s_req[s].sel);
					end else begin
						nxt[s].dat_r = slv_mem[s][idx];
					end
				end else begin
					slv_wait[s]--;
				end
			end
		end
		#1;
		for (int s = 0; s < 3; s++) begin
			s_rsp[s] = nxt[s];
		end
	end

	// Starts 1 ns after an edge and returns 1 ns after the edge that ended the cycle
	task automatic run_cycle(input int m, input logic [31:0] adr, input logic we,
			input logic [31:0] dat, input logic [3:0] sel,
			output logic [31:0] rdat, output logic ack, output logic err);
		drv_cti[m] = 3'($urandom_range(7, 0));
		drv_bte[m] = 2'($urandom_range(3, 0));
		m_req[m].adr = adr;
		m_req[m].dat_w = dat;
		m_req[m].sel = sel;
		m_req[m].we = we;
		m_req[m].cti = drv_cti[m];
		m_req[m].bte = drv_bte[m];
		m_req[m].cyc = 1'b1;
		m_req[m].stb = 1'b1;
		do begin
			@(posedge clk);
		end while (!m_rsp[m].ack && !m_rsp[m].err);
		rdat = m_rsp[m].dat_r;
		ack = m_rsp[m].ack;
		err = m_rsp[m].err;
		#1;
		m_req[m].cyc = 1'b0;
		m_req[m].stb = 1'b0;
	endtask

	// One access with response and read data checked against the model
	task automatic access(input int m, input int tgt, input int wrd, input logic we,
			input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] adr;
		logic [31:0] rdat;
		logic ack;
		logic err;
		if (tgt == 3) adr = UNMAPPED_BASE + 32'(wrd * 4);
		else adr = WINDOWS[tgt].base + 32'(wrd * 4);
		run_cycle(m, adr, we, dat, sel, rdat, ack, err);
		check($sformatf("m_rsp[%0d].ack", m), 64'(ack), 64'(tgt != 3));
		check($sformatf("m_rsp[%0d].err", m), 64'(err), 64'(tgt == 3));
		if (tgt != 3 && ack) begin
			if (we) ref_mem[tgt][wrd] = merge_bytes(ref_mem[tgt][wrd], dat, sel);
			else check($sformatf("m_rsp[%0d].dat_r", m), 64'(rdat), 64'(ref_mem[tgt][wrd]));
		end
	endtask

	task automatic check_quiet();
		for (int i = 0; i < 3; i++) begin
			check($sformatf("s_req[%0d].cyc", i), 64'(s_req[i].cyc), 64'd0);
			check($sformatf("s_req[%0d].stb", i), 64'(s_req[i].stb), 64'd0);
			check($sformatf("m_rsp[%0d].ack", i), 64'(m_rsp[i].ack), 64'd0);
			check($sformatf("m_rsp[%0d].err", i), 64'(m_rsp[i].err), 64'd0);
		end
	endtask

	task automatic apply_reset();
		rstn = 1'b0;
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge clk);
			// Flops are unknown until the first reset edge
			if (i > 0) check_quiet();
		end
		#1;
		rstn = 1'b1;
	endtask

	task automatic report_test(input string name);
		$display("Test %-14s %s", name, (n_errors == err_mark) ? "pass" : "fail");
		err_mark = n_errors;
	endtask

	task automatic fair_master(input int m);
		for (int n = 0; n < N_FAIR; n++) begin
			access(m, 1, m, 1'b1, $urandom, 4'hf);
		end
	endtask

	task automatic random_master(input int m);
		int gap;
		for (int n = 0; n < N_RAND / 3; n++) begin
			access(m, $urandom_range(3, 0), $urandom_range(255, 0), 1'($urandom_range(1, 0)),
				$urandom, 4'($urandom_range(15, 0)));
			gap = $urandom_range(2, 0);
			if (gap > 0) begin
				repeat (gap) @(posedge clk);
				#1;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h15bef4af));
		rstn = 1'b0;
		m_req = '0;
		s_rsp = '0;
		slv_pending = '0;
		fair_on = 1'b0;
		n_checks = 0;
		n_errors = 0;
		err_mark = 0;
		for (int s = 0; s < 3; s++) begin
			slv_wait[s] = 0;
			slv_stb_cnt[s] = 0;
			slv_last[s] = '0;
			for (int i = 0; i < 256; i++) begin
				slv_mem[s][i] = init_word(s, i);
				ref_mem[s][i] = init_word(s, i);
			end
		end

		// Quiet during reset and while masters stay idle after it
		apply_reset();
		repeat (4) begin
			@(posedge clk);
			check_quiet();
		end
		#1;
		report_test("reset_quiet");

		// Each master alone in each window writes and reads back
		for (int m = 0; m < 3; m++) begin
			for (int s = 0; s < 3; s++) begin
				word = $urandom_range(255, 0);
				wdat = $urandom;
				wsel = 4'($urandom_range(15, 1));
				access(m, s, word, 1'b1, wdat, wsel);
				check("slave.adr", 64'(slv_last[s].adr), 64'(WINDOWS[s].base + 32'(word * 4)));
				check("slave.dat_w", 64'(slv_last[s].dat_w), 64'(wdat));
				check("slave.sel", 64'(slv_last[s].sel), 64'(wsel));
				check("slave.we", 64'(slv_last[s].we), 64'd1);
				check("slave.cti", 64'(slv_last[s].cti), 64'(drv_cti[m]));
				check("slave.bte", 64'(slv_last[s].bte), 64'(drv_bte[m]));
				access(m, s, word, 1'b0, 32'h0, 4'hf);
				check("slave.adr", 64'(slv_last[s].adr), 64'(WINDOWS[s].base + 32'(word * 4)));
				check("slave.sel", 64'(slv_last[s].sel), 64'hf);
				check("slave.we", 64'(slv_last[s].we), 64'd0);
			end
		end
		report_test("routing_data");

		// Unmapped addresses end in err and never reach a slave
		stb_before = slv_stb_cnt[0] + slv_stb_cnt[1] + slv_stb_cnt[2];
		for (int m = 0; m < 3; m++) begin
			access(m, 3, $urandom_range(255, 0), 1'b0, 32'h0, 4'hf);
		end
		check("slave strobes", 64'(slv_stb_cnt[0] + slv_stb_cnt[1] + slv_stb_cnt[2]),
			64'(stb_before));
		report_test("decode_error");

		// Fresh reset so the arbiter starts from master 0
		apply_reset();
		fair_on = 1'b1;
		fork
			fair_master(0);
			fair_master(1);
			fair_master(2);
		join
		fair_on = 1'b0;
		check("fair_order.size", 64'(fair_order.size()), 64'(3 * N_FAIR));
		last = 2;
		left = '{N_FAIR, N_FAIR, N_FAIR};
		for (int k = 0; k < fair_order.size() && k < 3 * N_FAIR; k++) begin
			exp_m = rr_next(last, {left[2] > 0, left[1] > 0, left[0] > 0});
			check($sformatf("fair_order[%0d]", k), 64'(fair_order[k]), 64'(exp_m));
			left[exp_m]--;
			last = exp_m;
		end
		report_test("round_robin");

		fork
			random_master(0);
			random_master(1);
			random_master(2);
		join
		report_test("random_traffic");

		assert_fails = wb_xbar_3x3_inst.assert_inst.fail_cnt;
		$display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
			n_checks, n_errors, assert_fails);
		if (n_errors == 0 && assert_fails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
